//--- hdl/core_pkg.sv
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [2:0]  reg_idx_t;
	typedef logic [3:0]  alu_opc_t;
	typedef logic [1:0]  mem_width_t;
	typedef logic [2:0]  branch_cond_t;

	typedef enum logic [1:0] {
		CLASS_ARITH  = 2'd0,
		CLASS_BRANCH = 2'd1,
		CLASS_MEM    = 2'd2,
		CLASS_OTHER  = 2'd3
	} instr_class_e;

	// ALU operations. Codes 12 and 13 both give zero.
	localparam alu_opc_t ALU_ADD   = 4'd0;
	localparam alu_opc_t ALU_ADC   = 4'd1;
	localparam alu_opc_t ALU_SUB   = 4'd2;
	localparam alu_opc_t ALU_SBC   = 4'd3;
	localparam alu_opc_t ALU_SHL   = 4'd4;
	localparam alu_opc_t ALU_LSR   = 4'd5;
	localparam alu_opc_t ALU_AND   = 4'd6;
	localparam alu_opc_t ALU_XOR   = 4'd7;
	localparam alu_opc_t ALU_BIC   = 4'd8;
	localparam alu_opc_t ALU_BIS   = 4'd9;
	localparam alu_opc_t ALU_OR    = 4'd10;
	localparam alu_opc_t ALU_MOVHI = 4'd11;
	localparam alu_opc_t ALU_ASR   = 4'd14;
	localparam alu_opc_t ALU_MOV   = 4'd15;

	localparam branch_cond_t COND_NEVER  = 3'd0;
	localparam branch_cond_t COND_NZ     = 3'd1;
	localparam branch_cond_t COND_Z      = 3'd2;
	localparam branch_cond_t COND_NC     = 3'd3;
	localparam branch_cond_t COND_C      = 3'd4;
	localparam branch_cond_t COND_ALWAYS = 3'd7;

	typedef struct packed {
		instr_class_e instr_class;
		logic [3:0]   opcode;
		logic         rb_form;
		reg_idx_t     rd;
		reg_idx_t     ra;
		reg_idx_t     rb;
		logic [15:0]  imm16;
	} instr_t;

	typedef struct packed {
		word_t        ra;
		word_t        rb;
		word_t        imm32;
		word_t        pc_plus_4;
		reg_idx_t     rd_sel;
		logic         update_rd;
		alu_opc_t     alu_opc;
		logic         alu_op1_ra;
		logic         alu_op2_rb;
		logic         mem_load;
		logic         mem_store;
		mem_width_t   mem_width;
		branch_cond_t branch_cond;
		instr_class_e instr_class;
		logic         is_call;
	} exec_ctrl_t;

	typedef struct packed {
		logic       branch_taken;
		word_t      alu_out;
		logic       mem_load;
		logic       mem_store;
		mem_width_t mem_width;
		word_t      wr_val;
		logic       wr_result;
		reg_idx_t   rd_sel;
	} exec_result_t;

endpackage

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input  core_pkg::alu_opc_t opc,
	input  core_pkg::word_t    op1,
	input  core_pkg::word_t    op2,
	input  logic               carry_in,
	input  core_pkg::word_t    imm,
	output core_pkg::word_t    result,
	output logic               carry,
	output logic               equal
);

	import core_pkg::*;

	logic [32:0] wide; // Bit 32 is the carry out.
	logic [4:0]  shamt;

	assign shamt = op2[4:0];

	always_comb begin
		wide = '0;

		case (opc)
		ALU_ADD: begin
			wide = {1'b0, op1} + {1'b0, op2};
		end
		ALU_ADC: begin
			wide = {1'b0, op1} + {1'b0, op2} + {32'b0, carry_in};
		end
		ALU_SUB: begin
			wide = {1'b0, op1} - {1'b0, op2};
		end
		ALU_SBC: begin
			wide = {1'b0, op1} - {1'b0, op2} + {32'b0, carry_in};
		end
		ALU_SHL: begin
			wide = {1'b0, op1} << shamt;
		end
		ALU_LSR: begin
			wide = {1'b0, op1 >> shamt};
		end
		ALU_AND: begin
			wide = {1'b0, op1 & op2};
		end
		ALU_XOR: begin
			wide = {1'b0, op1 ^ op2};
		end
		ALU_BIC: begin
			wide = {1'b0, op1 & ~(32'h1 << shamt)};
		end
		ALU_BIS: begin
			wide = {1'b0, op1 | (32'h1 << shamt)};
		end
		ALU_OR: begin
			wide = {1'b0, op1 | op2};
		end
		ALU_MOVHI: begin
			wide = {1'b0, imm[15:0], 16'h0000};
		end
		ALU_ASR: begin
			wide = {1'b0, $signed(op1) >>> shamt};
		end
		ALU_MOV: begin
			wide = {1'b0, op1};
		end
		default: begin
			wide = '0; // Codes 12 and 13.
		end
		endcase
	end

	assign result = wide[31:0];
	assign carry  = wide[32];
	assign equal  = op1 == op2;

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               arst_n,
	input  core_pkg::reg_idx_t ra_idx,
	input  core_pkg::reg_idx_t rb_idx,
	input  logic               wr_en,
	input  core_pkg::reg_idx_t wr_idx,
	input  core_pkg::word_t    wr_data,
	output core_pkg::word_t    ra_val,
	output core_pkg::word_t    rb_val
);

	import core_pkg::*;

	word_t regs [8];

	assign ra_val = regs[ra_idx];
	assign rb_val = regs[rb_idx];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Writeback from execute must carry a defined value.
	a_wr_data_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		wr_en |-> !$isunknown(wr_data)
	);

endmodule

//--- hdl/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                instr_valid,
	input  core_pkg::instr_t    instr,
	input  core_pkg::word_t     pc,
	input  core_pkg::word_t     ra_val,
	input  core_pkg::word_t     rb_val,
	output core_pkg::reg_idx_t  ra_idx,
	output core_pkg::reg_idx_t  rb_idx,
	output core_pkg::exec_ctrl_t ctrl
);

	import core_pkg::*;

	// Bubble with no strobes, no flag update and no branch.
	localparam exec_ctrl_t CTRL_IDLE = '{instr_class: CLASS_OTHER, default: '0};

	exec_ctrl_t ctrl_nxt;
	word_t      imm32;
	word_t      pc_plus_4;

	assign ra_idx = instr.ra; // Register file reads are combinational.
	assign rb_idx = instr.rb;

	assign imm32     = {{16{instr.imm16[15]}}, instr.imm16};
	assign pc_plus_4 = pc + 32'd4;

	always_comb begin
		ctrl_nxt = CTRL_IDLE;

		if (instr_valid) begin
			ctrl_nxt.ra          = ra_val;
			ctrl_nxt.rb          = rb_val;
			ctrl_nxt.imm32       = imm32;
			ctrl_nxt.pc_plus_4   = pc_plus_4;
			ctrl_nxt.rd_sel      = instr.rd;
			ctrl_nxt.instr_class = instr.instr_class;

			case (instr.instr_class)
			CLASS_BRANCH: begin
				// Register target when rb_form is set, else pc relative.
				ctrl_nxt.alu_opc     = ALU_ADD;
				ctrl_nxt.alu_op1_ra  = instr.rb_form;
				ctrl_nxt.alu_op2_rb  = 1'b0;
				ctrl_nxt.branch_cond = instr.opcode[2:0];
				ctrl_nxt.is_call     = instr.opcode[3];
				ctrl_nxt.update_rd   = instr.opcode[3]; // Link write.
			end
			CLASS_MEM: begin
				ctrl_nxt.alu_opc    = ALU_ADD; // Address is ra + imm.
				ctrl_nxt.alu_op1_ra = 1'b1;
				ctrl_nxt.alu_op2_rb = 1'b0;
				ctrl_nxt.mem_store  = instr.opcode[3];
				ctrl_nxt.mem_load   = ~instr.opcode[3];
				ctrl_nxt.mem_width  = instr.opcode[1:0];
			end
			default: begin
				// Arith and other decode alike and differ only in the flags.
				ctrl_nxt.alu_opc    = instr.opcode;
				ctrl_nxt.alu_op1_ra = 1'b1;
				ctrl_nxt.alu_op2_rb = instr.rb_form;
				ctrl_nxt.update_rd  = 1'b1;
			end
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl <= CTRL_IDLE;
		end else begin
			ctrl <= ctrl_nxt;
		end
	end

	// A memory access is either a load or a store.
	a_load_store_excl: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(ctrl.mem_load && ctrl.mem_store)
	);

endmodule

//--- hdl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
	input  logic                  clk,
	input  logic                  arst_n,
	input  core_pkg::exec_ctrl_t  ctrl,
	output core_pkg::exec_result_t result
);

	import core_pkg::*;

	word_t op1;
	word_t op2;
	word_t alu_q;
	word_t wb_val;
	logic  alu_c;
	logic  alu_eq;
	logic  cond_met;

	// Private status flags.
	logic  z_flag;
	logic  c_flag;

	assign op1 = ctrl.alu_op1_ra ? ctrl.ra : ctrl.pc_plus_4;
	assign op2 = ctrl.alu_op2_rb ? ctrl.rb : ctrl.imm32;

	alu alu_i (
		.opc      (ctrl.alu_opc),
		.op1      (op1),
		.op2      (op2),
		.carry_in (c_flag),
		.imm      (ctrl.imm32),
		.result   (alu_q),
		.carry    (alu_c),
		.equal    (alu_eq)
	);

	always_comb begin
		case (ctrl.branch_cond)
		COND_ALWAYS: cond_met = 1'b1;
		COND_NZ:     cond_met = ~z_flag;
		COND_Z:      cond_met = z_flag;
		COND_NC:     cond_met = ~c_flag;
		COND_C:      cond_met = c_flag;
		default:     cond_met = 1'b0;
		endcase
	end

	// Link beats store data beats ALU.
	assign wb_val = ctrl.is_call ? ctrl.pc_plus_4 :
			ctrl.mem_store ? ctrl.rb : alu_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			z_flag <= 1'b0;
			c_flag <= 1'b0;
		end else if (ctrl.instr_class == CLASS_ARITH) begin
			z_flag <= alu_eq;
			c_flag <= alu_c;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= '0;
		end else begin
			result.branch_taken <= ctrl.instr_class == CLASS_BRANCH && cond_met;
			result.alu_out      <= alu_q;
			result.mem_load     <= ctrl.mem_load;
			result.mem_store    <= ctrl.mem_store;
			result.mem_width    <= ctrl.mem_width;
			result.wr_val       <= wb_val;
			result.wr_result    <= ctrl.update_rd;
			result.rd_sel       <= ctrl.rd_sel;
		end
	end

	a_taken_needs_branch: assert property (
		@(posedge clk) disable iff (!arst_n)
		result.branch_taken |-> $past(ctrl.instr_class) == CLASS_BRANCH
	);

endmodule

//--- hdl/exec_core.sv
`timescale 1ns/1ps

module exec_core (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   instr_valid,
	input  core_pkg::instr_t       instr,
	input  core_pkg::word_t        pc,
	output core_pkg::exec_result_t result
);

	import core_pkg::*;

	reg_idx_t   ra_idx;
	reg_idx_t   rb_idx;
	word_t      ra_val;
	word_t      rb_val;
	exec_ctrl_t ctrl;

	instr_decode decode_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.ra_val      (ra_val),
		.rb_val      (rb_val),
		.ra_idx      (ra_idx),
		.rb_idx      (rb_idx),
		.ctrl        (ctrl)
	);

	// Write port fed straight from the execute result.
	reg_file reg_file_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.ra_idx  (ra_idx),
		.rb_idx  (rb_idx),
		.wr_en   (result.wr_result),
		.wr_idx  (result.rd_sel),
		.wr_data (result.wr_val),
		.ra_val  (ra_val),
		.rb_val  (rb_val)
	);

	exec_stage exec_i (
		.clk    (clk),
		.arst_n (arst_n),
		.ctrl   (ctrl),
		.result (result)
	);

endmodule

//--- tb/exec_core_tb.sv
`timescale 1ns/1ps

module exec_core_tb;

	import core_pkg::*;

	typedef struct packed {
		logic [2:0]   test_id;
		logic         valid;
		logic         check;
		instr_t       instr;
		word_t        pc;
		exec_result_t exp;
	} step_t;

	logic         clk;
	logic         arst_n;
	logic         instr_valid;
	instr_t       instr;
	word_t        pc;
	exec_result_t result;

	step_t steps[$];
	int    mismatches;
	int    test_mismatches;
	int    tests_passed;
	int    tests_failed;

	exec_core exec_core_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.result      (result)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
	end

	function automatic instr_t encode(instr_class_e cls, logic [3:0] opc, logic rb_form,
			reg_idx_t rd, reg_idx_t ra, reg_idx_t rb, logic [15:0] imm);
		instr_t w;
		w.instr_class = cls;
		w.opcode      = opc;
		w.rb_form     = rb_form;
		w.rd          = rd;
		w.ra          = ra;
		w.rb          = rb;
		w.imm16       = imm;
		return w;
	endfunction

	function automatic exec_result_t make_result(logic taken, word_t alu_out, logic load,
			logic store, mem_width_t width, word_t wr_val, logic wr_result, reg_idx_t rd_sel);
		exec_result_t r;
		r.branch_taken = taken;
		r.alu_out      = alu_out;
		r.mem_load     = load;
		r.mem_store    = store;
		r.mem_width    = width;
		r.wr_val       = wr_val;
		r.wr_result    = wr_result;
		r.rd_sel       = rd_sel;
		return r;
	endfunction

	function automatic string test_name(logic [2:0] id);
		case (id)
		3'd0:    return "reset";
		3'd1:    return "alu";
		3'd2:    return "flags";
		3'd3:    return "call";
		default: return "memory";
		endcase
	endfunction

	task automatic add_step(logic [2:0] id, logic valid, logic check, instr_t ins, word_t pc_val,
			exec_result_t exp);
		step_t s;
		s.test_id = id;
		s.valid   = valid;
		s.check   = check;
		s.instr   = ins;
		s.pc      = pc_val;
		s.exp     = exp;
		steps.push_back(s);
	endtask

	// Register writing ALU op with wr_val equal to alu_out.
	task automatic add_alu(logic [2:0] id, instr_class_e cls, alu_opc_t opc, logic rb_form,
			reg_idx_t rd, reg_idx_t ra, reg_idx_t rb, logic [15:0] imm, word_t exp_val);
		add_step(id, 1'b1, 1'b1, encode(cls, opc, rb_form, rd, ra, rb, imm), 32'h0,
			make_result(1'b0, exp_val, 1'b0, 1'b0, 2'd0, exp_val, 1'b1, rd));
	endtask

	task automatic build_table();
		exec_result_t idle;
		idle = '0;
		add_step(3'd0, 1'b0, 1'b1, encode(CLASS_ARITH, ALU_OR, 1'b0, 3'd2, 3'd0, 3'd0, 16'h00ff),
			32'h40, idle);
		add_step(3'd0, 1'b0, 1'b1, '0, 32'h0, idle);
		add_alu(3'd1, CLASS_ARITH, ALU_OR, 1'b0, 3'd1, 3'd0, 3'd0, 16'h1234, 32'h0000_1234);
		add_alu(3'd1, CLASS_ARITH, ALU_MOVHI, 1'b0, 3'd2, 3'd0, 3'd0, 16'habcd, 32'habcd_0000);
		add_alu(3'd1, CLASS_ARITH, ALU_OR, 1'b0, 3'd2, 3'd2, 3'd0, 16'h5678, 32'habcd_5678);
		add_alu(3'd1, CLASS_ARITH, ALU_ADD, 1'b1, 3'd3, 3'd1, 3'd2, 16'h0, 32'habcd_68ac);
		add_alu(3'd1, CLASS_ARITH, ALU_ADD, 1'b0, 3'd4, 3'd1, 3'd0, 16'h0010, 32'h0000_1244);
		add_alu(3'd1, CLASS_ARITH, ALU_SUB, 1'b1, 3'd5, 3'd1, 3'd2, 16'h0, 32'h5432_bbbc); // Borrow.
		add_alu(3'd1, CLASS_ARITH, ALU_SBC, 1'b1, 3'd6, 3'd1, 3'd2, 16'h0, 32'h5432_bbbd);
		add_alu(3'd1, CLASS_ARITH, ALU_ADC, 1'b0, 3'd6, 3'd1, 3'd0, 16'h0001, 32'h0000_1236);
		add_alu(3'd1, CLASS_ARITH, ALU_LSR, 1'b0, 3'd6, 3'd2, 3'd0, 16'h0004, 32'h0abc_d567);
		add_alu(3'd1, CLASS_ARITH, ALU_ASR, 1'b0, 3'd6, 3'd2, 3'd0, 16'h0008, 32'hffab_cd56);
		add_alu(3'd1, CLASS_ARITH, ALU_BIC, 1'b0, 3'd6, 3'd2, 3'd0, 16'h0003, 32'habcd_5670);
		add_alu(3'd1, CLASS_ARITH, ALU_BIS, 1'b0, 3'd6, 3'd1, 3'd0, 16'h001f, 32'h8000_1234);
		add_alu(3'd1, CLASS_ARITH, ALU_XOR, 1'b1, 3'd6, 3'd1, 3'd2, 16'h0, 32'habcd_444c);
		// Zero flag set, then held across a move.
		add_alu(3'd2, CLASS_ARITH, ALU_SUB, 1'b1, 3'd6, 3'd1, 3'd1, 16'h0, 32'h0);
		add_alu(3'd2, CLASS_OTHER, ALU_MOV, 1'b0, 3'd5, 3'd2, 3'd0, 16'h0, 32'habcd_5678);
		add_step(3'd2, 1'b1, 1'b1, encode(CLASS_BRANCH, 4'b0010, 1'b0, 3'd0, 3'd0, 3'd0, 16'h0020),
			32'h100, make_result(1'b1, 32'h124, 1'b0, 1'b0, 2'd0, 32'h124, 1'b0, 3'd0));
		add_step(3'd2, 1'b1, 1'b0, encode(CLASS_ARITH, ALU_OR, 1'b0, 3'd4, 3'd0, 3'd0, 16'hffff),
			32'h0, idle);
		add_alu(3'd2, CLASS_ARITH, ALU_ADD, 1'b0, 3'd6, 3'd4, 3'd0, 16'h0001, 32'h0); // Carry out.
		add_step(3'd2, 1'b1, 1'b1, encode(CLASS_BRANCH, 4'b0100, 1'b0, 3'd0, 3'd0, 3'd0, 16'hfff0),
			32'h200, make_result(1'b1, 32'h1f4, 1'b0, 1'b0, 2'd0, 32'h1f4, 1'b0, 3'd0));
		add_step(3'd2, 1'b1, 1'b1, encode(CLASS_BRANCH, 4'b0011, 1'b0, 3'd0, 3'd0, 3'd0, 16'h0008),
			32'h300, make_result(1'b0, 32'h30c, 1'b0, 1'b0, 2'd0, 32'h30c, 1'b0, 3'd0));
		add_step(3'd2, 1'b1, 1'b1, encode(CLASS_BRANCH, 4'b0000, 1'b0, 3'd0, 3'd0, 3'd0, 16'h0004),
			32'h400, make_result(1'b0, 32'h408, 1'b0, 1'b0, 2'd0, 32'h408, 1'b0, 3'd0));
		// Call through r1 with the link in r7.
		add_step(3'd3, 1'b1, 1'b1, encode(CLASS_BRANCH, 4'b1111, 1'b1, 3'd7, 3'd1, 3'd0, 16'h0),
			32'h500, make_result(1'b1, 32'h1234, 1'b0, 1'b0, 2'd0, 32'h504, 1'b1, 3'd7));
		add_alu(3'd3, CLASS_OTHER, ALU_MOV, 1'b0, 3'd6, 3'd7, 3'd0, 16'h0, 32'h0000_0504);
		add_step(3'd4, 1'b1, 1'b1, encode(CLASS_MEM, 4'b0010, 1'b0, 3'd3, 3'd2, 3'd0, 16'hfffc),
			32'h0, make_result(1'b0, 32'habcd_5674, 1'b1, 1'b0, 2'd2, 32'habcd_5674, 1'b0, 3'd3));
		add_step(3'd4, 1'b1, 1'b1, encode(CLASS_MEM, 4'b1001, 1'b0, 3'd0, 3'd1, 3'd3, 16'h0008),
			32'h0, make_result(1'b0, 32'h123c, 1'b0, 1'b1, 2'd1, 32'habcd_68ac, 1'b0, 3'd0));
	endtask

	task automatic check_field(string name, word_t exp_val, word_t act_val);
		if (exp_val !== act_val) begin
			$display("FAIL %0t ns %s expected %h got %h", $time, name, exp_val, act_val);
			mismatches++;
			test_mismatches++;
		end
	endtask

	task automatic compare_result(exec_result_t exp);
		check_field("result.branch_taken", 32'(exp.branch_taken), 32'(result.branch_taken));
		check_field("result.alu_out", exp.alu_out, result.alu_out);
		check_field("result.mem_load", 32'(exp.mem_load), 32'(result.mem_load));
		check_field("result.mem_store", 32'(exp.mem_store), 32'(result.mem_store));
		check_field("result.mem_width", 32'(exp.mem_width), 32'(result.mem_width));
		check_field("result.wr_val", exp.wr_val, result.wr_val);
		check_field("result.wr_result", 32'(exp.wr_result), 32'(result.wr_result));
		check_field("result.rd_sel", 32'(exp.rd_sel), 32'(result.rd_sel));
	endtask

	task automatic report_test(logic [2:0] id);
		if (test_mismatches == 0) begin
			tests_passed++;
			$display("test %0d %s: pass", id, test_name(id));
		end else begin
			tests_failed++;
			$display("test %0d %s: fail, %0d mismatches", id, test_name(id), test_mismatches);
		end
		test_mismatches = 0;
	endtask

	// One instruction every four cycles, so writeback lands before the next read.
	task automatic run_steps();
		for (int i = 0; i < steps.size(); i++) begin
			@(posedge clk);
			instr_valid <= steps[i].valid;
			instr       <= steps[i].instr;
			pc          <= steps[i].pc;
			@(posedge clk);
			instr_valid <= 1'b0;
			@(posedge clk); // Result registered here.
			@(negedge clk);
			if (steps[i].check) begin
				compare_result(steps[i].exp);
			end
			@(posedge clk);
			if (i == steps.size() - 1 || steps[i + 1].test_id != steps[i].test_id) begin
				report_test(steps[i].test_id);
			end
		end
	endtask

	initial begin
		int reset_wait;
		instr_valid     = 1'b0;
		instr           = '0;
		pc              = '0;
		mismatches      = 0;
		test_mismatches = 0;
		tests_passed    = 0;
		tests_failed    = 0;
		reset_wait      = 0;
		build_table();
		while (arst_n !== 1'b1 && reset_wait < 10) begin
			@(posedge clk);
			reset_wait++;
		end
		if (arst_n !== 1'b1) begin
			$display("Timeout: reset still asserted after %0d cycles", reset_wait);
			$display("Errors found");
			$finish;
		end else begin
			run_steps();
			$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
			if (mismatches == 0) begin
				$display("No errors");
			end else begin
				$display("Errors found");
			end
			$finish;
		end
	end

endmodule

//--- sources.f
hdl/core_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/instr_decode.sv
hdl/exec_stage.sv
hdl/exec_core.sv
tb/exec_core_tb.sv

//--- Makefile
BIN  = obj_dir/Vexec_core_tb
SRCS = $(shell cat sources.f)

.PHONY: run clean

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'No errors'

$(BIN): sources.f $(SRCS)
	verilator --binary --timing --assert --top-module exec_core_tb -f sources.f

clean:
	rm -rf obj_dir
